/* include/mem_lat_emu_config.svh */
`ifndef MEM_LAT_EMU_CONFIG_SVH
`define MEM_LAT_EMU_CONFIG_SVH

// address and latency table geometry
`define MLE_ADDR_W 27
`define MLE_TBL_W 8
`define MLE_LAT_W 5

// lane count, must be a power of two
`define MLE_LANES 4

// per lane emulated cache and result queue
`define MLE_CACHE_SZ 8
`define MLE_LANE_DEPTH 4

// credits granted at the request and response ports
`define MLE_REQ_CREDITS 4
`define MLE_RESP_CREDITS 2

`endif

/* hdl/mem_lat_emu_pkg.sv */
`include "mem_lat_emu_config.svh"

package mem_lat_emu_pkg;

	localparam int LANE_W = $clog2(`MLE_LANES);
	localparam int TBL_SIZE = 1 << `MLE_TBL_W;

	typedef struct packed {
		logic valid;
		logic [`MLE_ADDR_W-1:0] addr;
	} req_t;

	typedef struct packed {
		logic valid;
		logic [`MLE_ADDR_W-1:0] addr;
	} fill_t;

	typedef struct packed {
		logic we;
		logic [`MLE_TBL_W-1:0] idx;
		logic [`MLE_LAT_W-1:0] lat;
	} cfg_t;

	// miss_wait: miss to an index that already had a miss outstanding
	typedef struct packed {
		logic valid;
		logic [`MLE_ADDR_W-1:0] addr;
		logic [`MLE_LAT_W-1:0] lat;
		logic hit;
		logic miss_wait;
	} resp_t;

	// lane select is the lowest address bits, the table index sits right above
	function automatic logic [LANE_W-1:0] lane_of(input logic [`MLE_ADDR_W-1:0] addr);
		return addr[LANE_W-1:0];
	endfunction

	function automatic logic [`MLE_TBL_W-1:0] tbl_idx(input logic [`MLE_ADDR_W-1:0] addr);
		return addr[LANE_W +: `MLE_TBL_W];
	endfunction

endpackage

/* hdl/lat_ram.sv */
`timescale 1ns/1ns

module lat_ram #(
	parameter int DATA_W = 5,
	parameter int ADDR_W = 8
) (
	input  logic              clk,
	input  logic [ADDR_W-1:0] a_addr,
	output logic [DATA_W-1:0] a_dout,
	input  logic              b_we,
	input  logic [ADDR_W-1:0] b_addr,
	input  logic [DATA_W-1:0] b_din,
	output logic [DATA_W-1:0] b_dout
);

	logic [DATA_W-1:0] mem [1 << ADDR_W];

	// port a is read only
	always_ff @(posedge clk)
	begin
		a_dout <= mem[a_addr];
	end

	// port b reads old data on a write
	always_ff @(posedge clk)
	begin
		if (b_we)
		begin
			mem[b_addr] <= b_din;
		end
		b_dout <= mem[b_addr];
	end

endmodule

/* hdl/req_dispatch.sv */
`timescale 1ns/1ns
`include "mem_lat_emu_config.svh"

module req_dispatch
	import mem_lat_emu_pkg::*;
(
	input  logic                  clk,
	input  logic                  resetb,
	input  req_t                  req,
	input  fill_t                 fill,
	output req_t                  lane_req [`MLE_LANES],
	output fill_t                 lane_fill [`MLE_LANES],
	input  logic [`MLE_LANES-1:0] lane_credit
);

	localparam int PTR_W = $clog2(`MLE_REQ_CREDITS);
	localparam int LCNT_W = $clog2(`MLE_LANE_DEPTH + 1);

	logic [`MLE_ADDR_W-1:0] sk_addr [`MLE_REQ_CREDITS];
	logic [PTR_W-1:0] sk_wp;
	logic [PTR_W-1:0] sk_rp;
	logic [PTR_W:0] sk_cnt;
	logic [LCNT_W-1:0] lane_cnt [`MLE_LANES];
	logic [`MLE_ADDR_W-1:0] head_addr;
	logic [LANE_W-1:0] head_lane;
	logic send;
	logic fill_vld;
	logic [`MLE_ADDR_W-1:0] fill_addr;

	// ************************************************************
	// skid buffer, never overflows since every entry holds a credit
	// ************************************************************
	assign head_addr = sk_addr[sk_rp];
	assign head_lane = lane_of(head_addr);
	// head blocks the buffer until its lane has room
	assign send = (sk_cnt != '0) && (lane_cnt[head_lane] != '0);

	always_ff @(posedge clk)
	begin
		if (req.valid)
		begin
			sk_addr[sk_wp] <= req.addr;
		end
		fill_addr <= fill.addr;
	end

	always_ff @(posedge clk)
	begin
		if (!resetb)
		begin
			sk_wp <= '0;
			sk_rp <= '0;
			sk_cnt <= '0;
			fill_vld <= 1'b0;
			for (int i = 0; i < `MLE_LANES; i++)
			begin
				lane_cnt[i] <= LCNT_W'(`MLE_LANE_DEPTH);
			end
		end
		else
		begin
			if (req.valid)
			begin
				sk_wp <= sk_wp + 1'b1;
			end
			if (send)
			begin
				sk_rp <= sk_rp + 1'b1;
			end
			sk_cnt <= sk_cnt + (PTR_W+1)'(req.valid) - (PTR_W+1)'(send);
			fill_vld <= fill.valid;
			for (int i = 0; i < `MLE_LANES; i++)
			begin
				lane_cnt[i] <= lane_cnt[i] - LCNT_W'(send && (head_lane == LANE_W'(i)))
					+ LCNT_W'(lane_credit[i]);
			end
		end
	end

	// fills are delayed one cycle to line up with a request leaving the buffer
	always_comb
	begin
		for (int i = 0; i < `MLE_LANES; i++)
		begin
			lane_req[i].valid = send && (head_lane == LANE_W'(i));
			lane_req[i].addr = head_addr;
			lane_fill[i].valid = fill_vld && (lane_of(fill_addr) == LANE_W'(i));
			lane_fill[i].addr = fill_addr;
		end
	end

endmodule

/* hdl/lat_lane.sv */
`timescale 1ns/1ns
`include "mem_lat_emu_config.svh"

module lat_lane
	import mem_lat_emu_pkg::*;
(
	input  logic                  clk,
	input  logic                  resetb,
	input  req_t                  req,
	input  fill_t                 fill,
	input  cfg_t                  cfg,
	input  logic [`MLE_TBL_W-1:0] rd_addr,
	output logic [`MLE_LAT_W-1:0] rd_data,
	output resp_t                 res,
	input  logic                  pop,
	output logic                  credit
);

	localparam int TAG_PTR_W = $clog2(`MLE_CACHE_SZ);
	localparam int Q_PTR_W = $clog2(`MLE_LANE_DEPTH);

	logic r_req_vld;
	logic [`MLE_ADDR_W-1:0] r_req_addr;
	logic r_fill_vld;
	logic [`MLE_ADDR_W-1:0] r_fill_addr;
	logic [`MLE_TBL_W-1:0] r_idx;
	logic [`MLE_TBL_W-1:0] req_idx;
	logic [`MLE_TBL_W-1:0] port_b_addr;
	logic [`MLE_LAT_W-1:0] ram_lat;

	logic [`MLE_ADDR_W-1:0] tag_addr [`MLE_CACHE_SZ];
	logic [`MLE_CACHE_SZ-1:0] tag_vld;
	logic [TAG_PTR_W-1:0] tag_wp;
	logic [TBL_SIZE-1:0] miss_pend;
	logic hit;
	logic miss_wait;

	resp_t q_ent [`MLE_LANE_DEPTH];
	logic [`MLE_LAT_W-1:0] q_tmr [`MLE_LANE_DEPTH];
	logic [Q_PTR_W-1:0] q_wp;
	logic [Q_PTR_W-1:0] q_rp;
	logic [Q_PTR_W:0] q_cnt;

	// table lookup starts while the request is being registered
	assign req_idx = tbl_idx(req.addr);
	assign port_b_addr = cfg.we ? cfg.idx : rd_addr;

	lat_ram #(
		.DATA_W(`MLE_LAT_W),
		.ADDR_W(`MLE_TBL_W)
	) u_ram (
		.clk   (clk),
		.a_addr(req_idx),
		.a_dout(ram_lat),
		.b_we  (cfg.we),
		.b_addr(port_b_addr),
		.b_din (cfg.lat),
		.b_dout(rd_data)
	);

	// ************************************************************
	// stage 1 registers
	// ************************************************************
	always_ff @(posedge clk)
	begin
		r_req_addr <= req.addr;
		r_fill_addr <= fill.addr;
	end

	always_ff @(posedge clk)
	begin
		if (!resetb)
		begin
			r_req_vld <= 1'b0;
			r_fill_vld <= 1'b0;
		end
		else
		begin
			r_req_vld <= req.valid;
			r_fill_vld <= fill.valid;
		end
	end

	assign r_idx = tbl_idx(r_req_addr);

	// ************************************************************
	// stage 2: tag compare and miss tracking
	// ************************************************************
	always_comb
	begin
		// a fill in the same cycle counts as a hit
		hit = r_fill_vld && (r_fill_addr == r_req_addr);
		for (int k = 0; k < `MLE_CACHE_SZ; k++)
		begin
			if (tag_vld[k] && (tag_addr[k] == r_req_addr))
			begin
				hit = 1'b1;
			end
		end
	end

	assign miss_wait = !hit && miss_pend[r_idx];

	always_ff @(posedge clk)
	begin
		if (r_fill_vld)
		begin
			tag_addr[tag_wp] <= r_fill_addr;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!resetb)
		begin
			tag_vld <= '0;
			tag_wp <= '0;
			miss_pend <= '0;
		end
		else
		begin
			if (r_req_vld && !hit)
			begin
				miss_pend[r_idx] <= 1'b1;
			end
			// ring overwrites the oldest tag, fill clears the index after a miss set
			if (r_fill_vld)
			begin
				tag_vld[tag_wp] <= 1'b1;
				tag_wp <= tag_wp + 1'b1;
				miss_pend[tbl_idx(r_fill_addr)] <= 1'b0;
			end
		end
	end

	// ************************************************************
	// hold queue, in order release on countdown
	// ************************************************************
	always_ff @(posedge clk)
	begin
		for (int k = 0; k < `MLE_LANE_DEPTH; k++)
		begin
			if (q_tmr[k] != '0)
			begin
				q_tmr[k] <= q_tmr[k] - 1'b1;
			end
		end
		if (r_req_vld)
		begin
			q_ent[q_wp] <= '{valid: 1'b1, addr: r_req_addr, lat: ram_lat,
				hit: hit, miss_wait: miss_wait};
			q_tmr[q_wp] <= ram_lat;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!resetb)
		begin
			q_wp <= '0;
			q_rp <= '0;
			q_cnt <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (r_req_vld)
			begin
				q_wp <= q_wp + 1'b1;
			end
			if (pop)
			begin
				q_rp <= q_rp + 1'b1;
			end
			q_cnt <= q_cnt + (Q_PTR_W+1)'(r_req_vld) - (Q_PTR_W+1)'(pop);
			credit <= pop;
		end
	end

	always_comb
	begin
		res = q_ent[q_rp];
		res.valid = (q_cnt != '0) && (q_tmr[q_rp] == '0);
	end

endmodule

/* hdl/resp_merge.sv */
`timescale 1ns/1ns
`include "mem_lat_emu_config.svh"

module resp_merge
	import mem_lat_emu_pkg::*;
(
	input  logic                  clk,
	input  logic                  resetb,
	input  resp_t                 lane_res [`MLE_LANES],
	output logic [`MLE_LANES-1:0] lane_pop,
	output resp_t                 resp,
	input  logic                  resp_credit
);

	localparam int CR_W = $clog2(`MLE_RESP_CREDITS + 1);

	logic [LANE_W-1:0] rr;
	logic [LANE_W-1:0] cand;
	logic [LANE_W-1:0] sel;
	logic found;
	logic take;
	logic [CR_W-1:0] cr_cnt;
	resp_t resp_r;
	logic resp_vld;

	// first released lane at or after the round robin pointer
	always_comb
	begin
		sel = rr;
		cand = rr;
		found = 1'b0;
		for (int k = 0; k < `MLE_LANES; k++)
		begin
			cand = rr + LANE_W'(k);
			if (!found && lane_res[cand].valid)
			begin
				sel = cand;
				found = 1'b1;
			end
		end
	end

	assign take = found && (cr_cnt != '0);
	assign lane_pop = take ? (`MLE_LANES'(1) << sel) : '0;

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			resp_r <= lane_res[sel];
		end
	end

	always_ff @(posedge clk)
	begin
		if (!resetb)
		begin
			rr <= '0;
			cr_cnt <= CR_W'(`MLE_RESP_CREDITS);
			resp_vld <= 1'b0;
		end
		else
		begin
			resp_vld <= take;
			if (take)
			begin
				rr <= sel + 1'b1;
			end
			cr_cnt <= cr_cnt - CR_W'(take) + CR_W'(resp_credit);
		end
	end

	always_comb
	begin
		resp = resp_r;
		resp.valid = resp_vld;
	end

endmodule

/* hdl/mem_lat_emu_top.sv */
`timescale 1ns/1ns
`include "mem_lat_emu_config.svh"

module mem_lat_emu_top
	import mem_lat_emu_pkg::*;
(
	input  logic                  clk,
	input  logic                  resetb,
	input  req_t                  req,
	input  fill_t                 fill,
	input  cfg_t                  cfg,
	input  logic [`MLE_TBL_W-1:0] cfg_rd_addr,
	output logic [`MLE_LAT_W-1:0] cfg_rd_data,
	output logic                  req_credit,
	output resp_t                 resp,
	input  logic                  resp_credit
);

	req_t lane_req [`MLE_LANES];
	fill_t lane_fill [`MLE_LANES];
	logic [`MLE_LANES-1:0] lane_credit;
	resp_t lane_res [`MLE_LANES];
	logic [`MLE_LANES-1:0] lane_pop;
	logic [`MLE_LAT_W-1:0] lane_rd_data [`MLE_LANES];

	req_dispatch u_dispatch (
		.clk        (clk),
		.resetb     (resetb),
		.req        (req),
		.fill       (fill),
		.lane_req   (lane_req),
		.lane_fill  (lane_fill),
		.lane_credit(lane_credit)
	);

	// every lane gets the table writes, read-back uses lane 0
	generate
		for (genvar g = 0; g < `MLE_LANES; g++)
		begin : g_lane
			lat_lane u_lane (
				.clk    (clk),
				.resetb (resetb),
				.req    (lane_req[g]),
				.fill   (lane_fill[g]),
				.cfg    (cfg),
				.rd_addr(cfg_rd_addr),
				.rd_data(lane_rd_data[g]),
				.res    (lane_res[g]),
				.pop    (lane_pop[g]),
				.credit (lane_credit[g])
			);
		end
	endgenerate

	resp_merge u_merge (
		.clk        (clk),
		.resetb     (resetb),
		.lane_res   (lane_res),
		.lane_pop   (lane_pop),
		.resp       (resp),
		.resp_credit(resp_credit)
	);

	assign cfg_rd_data = lane_rd_data[0];
	// at most one pop per cycle, each frees one upstream credit
	assign req_credit = |lane_pop;

endmodule

/* bench/mem_lat_emu_sva.sv */
`timescale 1ns/1ns
`include "mem_lat_emu_config.svh"

module mem_lat_emu_sva
	import mem_lat_emu_pkg::*;
(
	input logic                  clk,
	input logic                  resetb,
	input logic                  req_credit,
	input resp_t                 resp,
	input logic                  resp_credit,
	input logic [`MLE_LANES-1:0] lane_pop,
	input resp_t                 lane_res [`MLE_LANES]
);

	logic [3:0] resp_cr;
	logic [`MLE_LANES-1:0] lane_rel;

	// response credits the top level holds as seen from its ports
	always_ff @(posedge clk)
	begin
		if (!resetb)
		begin
			resp_cr <= 4'(`MLE_RESP_CREDITS);
		end
		else
		begin
			resp_cr <= resp_cr + 4'(resp_credit) - 4'(resp.valid);
		end
	end

	// lanes holding a released result
	always_comb
	begin
		for (int i = 0; i < `MLE_LANES; i++)
		begin
			lane_rel[i] = lane_res[i].valid;
		end
	end

	a_resp_has_credit: assert property (@(posedge clk) disable iff (!resetb)
		resp.valid |-> resp_cr != '0)
		else $error("response sent with no credit available");

	a_quiet_after_reset: assert property (@(posedge clk)
		!resetb |=> !resp.valid && !req_credit)
		else $error("response or request credit active right after reset");

	a_one_pop: assert property (@(posedge clk) disable iff (!resetb)
		$onehot0(lane_pop) && ((lane_pop & ~lane_rel) == '0))
		else $error("more than one pop in a cycle or a pop with no released result");

endmodule

bind mem_lat_emu_top mem_lat_emu_sva u_sva (
	.clk        (clk),
	.resetb     (resetb),
	.req_credit (req_credit),
	.resp       (resp),
	.resp_credit(resp_credit),
	.lane_pop   (lane_pop),
	.lane_res   (lane_res)
);

/* bench/mem_lat_emu_tb.sv */
`timescale 1ns/1ns
`include "mem_lat_emu_config.svh"

module mem_lat_emu_tb
	import mem_lat_emu_pkg::*;
();

	localparam int N_TRAFFIC = 400;
	localparam int HOLD_CYCLES = 80;
	localparam int WAIT_LIMIT = 2000;

	logic clk;
	logic resetb;
	req_t req;
	fill_t fill;
	cfg_t cfg;
	logic [`MLE_TBL_W-1:0] cfg_rd_addr;
	logic [`MLE_LAT_W-1:0] cfg_rd_data;
	logic req_credit;
	resp_t resp;
	logic resp_credit;

	logic [31:0] rng;
	logic [31:0] cyc;
	logic [`MLE_LAT_W-1:0] shadow [TBL_SIZE];
	logic [`MLE_ADDR_W-1:0] ring [`MLE_LANES][`MLE_CACHE_SZ];
	logic [`MLE_CACHE_SZ-1:0] ring_vld [`MLE_LANES];
	int ring_ptr [`MLE_LANES];
	logic [TBL_SIZE-1:0] pend [`MLE_LANES];

	// expected results per lane in request order
	resp_t exp_ent [`MLE_LANES][16];
	logic [31:0] exp_cyc [`MLE_LANES][16];
	logic [3:0] exp_wp [`MLE_LANES];
	logic [3:0] exp_rp [`MLE_LANES];
	int resp_lane;
	resp_t exp_cur;
	logic [31:0] exp_cur_cyc;
	logic exp_cur_any;

	int reqs_sent;
	int credits_recv;
	int resps_seen;
	int credits_sent;
	logic rd_chk;
	logic [`MLE_LAT_W-1:0] rd_exp;

	mem_lat_emu_top uut (
		.clk        (clk),
		.resetb     (resetb),
		.req        (req),
		.fill       (fill),
		.cfg        (cfg),
		.cfg_rd_addr(cfg_rd_addr),
		.cfg_rd_data(cfg_rd_data),
		.req_credit (req_credit),
		.resp       (resp),
		.resp_credit(resp_credit)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int lane_from_addr(input logic [`MLE_ADDR_W-1:0] a);
		return int'(a % `MLE_LANES);
	endfunction

	function automatic int index_from_addr(input logic [`MLE_ADDR_W-1:0] a);
		return int'((a / `MLE_LANES) % TBL_SIZE);
	endfunction

	// small address pool of 8 indices and 4 upper values per lane
	function automatic logic [`MLE_ADDR_W-1:0] pool_addr(input logic [6:0] x);
		logic [`MLE_ADDR_W-1:0] a;
		a = '0;
		a[LANE_W-1:0] = x[1:0];
		a[LANE_W +: 3] = x[4:2];
		a[LANE_W + `MLE_TBL_W +: 2] = x[6:5];
		return a;
	endfunction

	function automatic logic in_ring(input int ln, input logic [`MLE_ADDR_W-1:0] a);
		logic found;
		found = 1'b0;
		for (int k = 0; k < `MLE_CACHE_SZ; k++)
		begin
			if (ring_vld[ln][k] && (ring[ln][k] == a))
			begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	function automatic int outstanding();
		int n;
		n = 0;
		for (int k = 0; k < `MLE_LANES; k++)
		begin
			n += int'(4'(exp_wp[k] - exp_rp[k]));
		end
		return n;
	endfunction

	task automatic stop_failed();
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		stop_failed();
	endtask

	task automatic report_timeout(input string what);
		$display("timed out waiting for %s", what);
		stop_failed();
	endtask

	task automatic clear_inputs();
		req.valid <= 1'b0;
		fill.valid <= 1'b0;
		cfg.we <= 1'b0;
		resp_credit <= 1'b0;
		rd_chk <= 1'b0;
	endtask

	task automatic write_entry(input int ix, input logic [`MLE_LAT_W-1:0] lat);
		@(posedge clk);
		clear_inputs();
		shadow[ix] = lat;
		cfg <= '{we: 1'b1, idx: `MLE_TBL_W'(ix), lat: lat};
	endtask

	task automatic read_entry(input int ix);
		@(posedge clk);
		clear_inputs();
		cfg_rd_addr <= `MLE_TBL_W'(ix);
		rd_chk <= 1'b1;
		rd_exp <= shadow[ix];
	endtask

	// lookup sees this cycle's fill but the miss state from before it
	task automatic record_request(input logic [`MLE_ADDR_W-1:0] a, input logic fv,
		input logic [`MLE_ADDR_W-1:0] fa);
		int ln;
		int ix;
		resp_t e;
		ln = lane_from_addr(a);
		ix = index_from_addr(a);
		e.valid = 1'b1;
		e.addr = a;
		e.lat = shadow[ix];
		e.hit = (fv && (fa == a)) || in_ring(ln, a);
		e.miss_wait = !e.hit && pend[ln][ix];
		if (!e.hit)
		begin
			pend[ln][ix] = 1'b1;
		end
		exp_ent[ln][exp_wp[ln]] <= e;
		exp_cyc[ln][exp_wp[ln]] <= cyc;
		exp_wp[ln] <= exp_wp[ln] + 1'b1;
		reqs_sent <= reqs_sent + 1;
		req <= '{valid: 1'b1, addr: a};
	endtask

	task automatic record_fill(input logic [`MLE_ADDR_W-1:0] a);
		int ln;
		ln = lane_from_addr(a);
		ring[ln][ring_ptr[ln]] = a;
		ring_vld[ln][ring_ptr[ln]] = 1'b1;
		ring_ptr[ln] = (ring_ptr[ln] + 1) % `MLE_CACHE_SZ;
		pend[ln][index_from_addr(a)] = 1'b0;
		fill <= '{valid: 1'b1, addr: a};
	endtask

	task automatic traffic_cycle(input logic allow_fill, input logic allow_req,
		input logic hold);
		logic [31:0] r;
		logic [`MLE_ADDR_W-1:0] ra;
		logic [`MLE_ADDR_W-1:0] fa;
		logic fv;
		logic rv;
		@(posedge clk);
		clear_inputs();
		rng = xorshift32(rng);
		r = rng;
		ra = pool_addr(r[6:0]);
		// now and then the fill lands on the request address
		fa = (r[27:26] == 2'b00) ? ra : pool_addr(r[14:8]);
		fv = allow_fill && (r[31:30] == 2'b00);
		rv = allow_req && (r[29:28] != 2'b00)
			&& (reqs_sent < credits_recv + `MLE_REQ_CREDITS);
		if (rv)
		begin
			record_request(ra, fv, fa);
		end
		if (fv)
		begin
			record_fill(fa);
		end
		if (!hold && r[25] && (credits_sent < resps_seen))
		begin
			resp_credit <= 1'b1;
			credits_sent <= credits_sent + 1;
		end
	endtask

	// ************************************************************
	// response monitor
	// ************************************************************
	assign resp_lane = lane_from_addr(resp.addr);
	assign exp_cur = exp_ent[resp_lane][exp_rp[resp_lane]];
	assign exp_cur_cyc = exp_cyc[resp_lane][exp_rp[resp_lane]];
	assign exp_cur_any = exp_wp[resp_lane] != exp_rp[resp_lane];

	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (!resetb)
		begin
			credits_recv <= 0;
			resps_seen <= 0;
			for (int k = 0; k < `MLE_LANES; k++)
			begin
				exp_rp[k] <= '0;
			end
		end
		else
		begin
			if (req_credit)
			begin
				credits_recv <= credits_recv + 1;
			end
			if (resp.valid)
			begin
				resps_seen <= resps_seen + 1;
				exp_rp[resp_lane] <= exp_rp[resp_lane] + 1'b1;
			end
		end
	end

	a_rd_back: assert property (@(posedge clk) disable iff (!resetb)
		rd_chk |=> cfg_rd_data == $past(rd_exp))
		else report_error("table read-back differs from the last write");
	a_resp_known: assert property (@(posedge clk) disable iff (!resetb)
		resp.valid |-> exp_cur_any)
		else report_error("response with no request outstanding in its lane");
	a_resp_order: assert property (@(posedge clk) disable iff (!resetb)
		resp.valid |-> resp.addr == exp_cur.addr)
		else report_error("response address out of request order");
	a_resp_lat: assert property (@(posedge clk) disable iff (!resetb)
		resp.valid |-> resp.lat == exp_cur.lat)
		else report_error("response latency differs from the table");
	a_resp_hit: assert property (@(posedge clk) disable iff (!resetb)
		resp.valid |-> resp.hit == exp_cur.hit)
		else report_error("wrong hit bit");
	a_resp_wait: assert property (@(posedge clk) disable iff (!resetb)
		resp.valid |-> resp.miss_wait == exp_cur.miss_wait)
		else report_error("wrong wait bit");
	a_resp_time: assert property (@(posedge clk) disable iff (!resetb)
		resp.valid |-> (cyc - exp_cur_cyc) >= (32'(exp_cur.lat) + 32'd3))
		else report_error("response arrived before its latency elapsed");
	a_resp_credit: assert property (@(posedge clk) disable iff (!resetb)
		resp.valid |-> resps_seen < (credits_sent + `MLE_RESP_CREDITS))
		else report_error("response beyond the returned credits");
	// each result taken from a lane frees one request credit and shows up a cycle later
	a_credit_per_resp: assert property (@(posedge clk) disable iff (!resetb)
		resp.valid == $past(req_credit))
		else report_error("request credit pulses do not match the responses");

	// ************************************************************
	// stimulus
	// ************************************************************
	initial
	begin
		int n;
		resetb = 1'b0;
		req = '0;
		fill = '0;
		cfg = '0;
		cfg_rd_addr = '0;
		resp_credit = 1'b0;
		rd_chk = 1'b0;
		rd_exp = '0;
		cyc = '0;
		rng = 32'hf313b6b4;
		reqs_sent = 0;
		credits_sent = 0;
		for (int k = 0; k < `MLE_LANES; k++)
		begin
			exp_wp[k] = '0;
			ring_vld[k] = '0;
			ring_ptr[k] = 0;
			pend[k] = '0;
		end
		repeat (5) @(posedge clk);
		resetb <= 1'b1;

		for (int i = 0; i < TBL_SIZE; i++)
		begin
			rng = xorshift32(rng);
			write_entry(i, rng[`MLE_LAT_W-1:0]);
		end
		// mixed writes and read-back
		for (int i = 0; i < 96; i++)
		begin
			rng = xorshift32(rng);
			if (rng[0])
			begin
				write_entry(int'(rng[15:8]), rng[16 +: `MLE_LAT_W]);
			end
			else
			begin
				read_entry(int'(rng[15:8]));
			end
		end

		for (int i = 0; i < N_TRAFFIC; i++)
		begin
			traffic_cycle(1'b1, 1'b1, 1'b0);
		end
		// back-pressure while requests go on as long as credits last
		for (int i = 0; i < HOLD_CYCLES; i++)
		begin
			traffic_cycle(1'b1, 1'b1, 1'b1);
		end
		for (int i = 0; i < N_TRAFFIC; i++)
		begin
			traffic_cycle(1'b1, 1'b1, 1'b0);
		end

		n = 0;
		while ((outstanding() != 0) || (credits_sent != resps_seen))
		begin
			if (n == WAIT_LIMIT)
			begin
				report_timeout("all outstanding responses");
			end
			else
			begin
				n++;
				traffic_cycle(1'b0, 1'b0, 1'b0);
			end
		end
		@(posedge clk);
		clear_inputs();
		repeat (2) @(posedge clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

/* mem_lat_emu.f */
+incdir+include
hdl/mem_lat_emu_pkg.sv
hdl/lat_ram.sv
hdl/req_dispatch.sv
hdl/lat_lane.sv
hdl/resp_merge.sv
hdl/mem_lat_emu_top.sv
bench/mem_lat_emu_sva.sv
bench/mem_lat_emu_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module mem_lat_emu_tb -f mem_lat_emu.f

out=$(./obj_dir/Vmem_lat_emu_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Test completed successfully"; then
	exit 0
fi
exit 1
